// ==== compile.f ====
+incdir+common
common/afu_pkg.sv
logic/afu_run_ctrl.sv
logic/mem_port_shim.sv
logic/afu_wrap.sv
dv/afu_wrap_props.sv
dv/afu_wrap_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= afu_wrap_tb
FILELIST ?= compile.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== dv/afu_wrap_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "afu_params.svh"

module afu_wrap_tb;
	import afu_pkg::*;

	localparam int nb = `AFU_NUM_BANKS;
	localparam int num_rows = 4;
	localparam int wait_limit = 64;

	// one test case
	// per-bank fields hold bank 0 in the low slot
	typedef struct packed {
		int busy_len;
		logic [nb-1:0][3:0] wr_cnt;
		logic [nb-1:0][3:0] rsp_cnt;
		logic mid_reset;
		logic [nb-1:0][`AFU_BUS_ADDR_W-1:0] base;
		core_addr_t [nb-1:0] addr;
		bus_addr_t [nb-1:0] exp_addr;
	} row_t;

	logic ap_clk;
	logic reset;
	logic ap_reset;
	logic ap_start;
	logic core_busy;
	logic [`AFU_BUS_ADDR_W-1:0] bank_base [nb];
	core_addr_t core_addr [nb];
	wr_beat_t wr_beat [nb];
	bus_addr_t bus_addr [nb];
	logic ap_done;
	logic ap_idle;
	logic core_reset;

	row_t rows [num_rows];

	// model of the DUT state, updated at every clock edge
	logic exp_run;
	logic exp_idle;
	int exp_pend;

	int errors;
	int timeouts;

	afu_wrap dut0 (
		.ap_clk     (ap_clk),
		.reset      (reset),
		.ap_reset   (ap_reset),
		.ap_start   (ap_start),
		.bank_base  (bank_base),
		.core_busy  (core_busy),
		.core_addr  (core_addr),
		.wr_beat    (wr_beat),
		.bus_addr   (bus_addr),
		.ap_done    (ap_done),
		.ap_idle    (ap_idle),
		.core_reset (core_reset)
	);

	always #20 ap_clk = ~ap_clk;

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			errors++;
			$display("[FAIL] %0t ns %s expected %0b actual %0b", $time, name, exp, act);
		end
	endtask

	task automatic check_bus_addr(input string name, input bus_addr_t exp, input bus_addr_t act);
		if (act !== exp) begin
			errors++;
			$display("[FAIL] %0t ns %s expected %h actual %h", $time, name, exp, act);
		end
	endtask

	task automatic check_count(input string name, input int exp, input int act);
		if (act != exp) begin
			errors++;
			$display("[FAIL] %0t ns %s expected %0d actual %0d", $time, name, exp, act);
		end
	endtask

	// zero-extend the core address, add the base, drop the carry out
	function automatic bus_addr_t rebase(
		input core_addr_t a,
		input logic [`AFU_BUS_ADDR_W-1:0] base
	);
		bus_addr_t r;
		logic [`AFU_BUS_ADDR_W-1:0] rd_ext;
		logic [`AFU_BUS_ADDR_W-1:0] wr_ext;
		rd_ext = {{(`AFU_BUS_ADDR_W - `AFU_CORE_ADDR_W){1'b0}}, a.rd};
		wr_ext = {{(`AFU_BUS_ADDR_W - `AFU_CORE_ADDR_W){1'b0}}, a.wr};
		r.rd = rd_ext + base;
		r.wr = wr_ext + base;
		return r;
	endfunction

	task automatic build_rows();
		// write and response counts as {bank 1, bank 0}
		rows[0].wr_cnt = {4'd1, 4'd1};
		rows[0].rsp_cnt = {4'd1, 4'd1};
		rows[0].mid_reset = 1'b0;
		// leaves two writes open after the core goes quiet
		rows[1].wr_cnt = {4'd2, 4'd3};
		rows[1].rsp_cnt = {4'd0, 4'd1};
		rows[1].mid_reset = 1'b0;
		rows[2].wr_cnt = {4'd0, 4'd2};
		rows[2].rsp_cnt = {4'd0, 4'd0};
		rows[2].mid_reset = 1'b1;
		rows[3].wr_cnt = {4'd2, 4'd1};
		rows[3].rsp_cnt = {4'd2, 4'd0};
		rows[3].mid_reset = 1'b0;
		for (int r = 0; r < num_rows; r++) begin
			rows[r].busy_len = $urandom_range(4, 12);
			for (int i = 0; i < nb; i++) begin
				rows[r].base[i] = (`AFU_BUS_ADDR_W)'({$urandom, $urandom});
				rows[r].addr[i].rd = (`AFU_CORE_ADDR_W)'($urandom);
				rows[r].addr[i].wr = (`AFU_CORE_ADDR_W)'($urandom);
			end
		end
		// all-ones base and address push the carry past the bus width
		rows[1].base[0] = '1;
		rows[1].addr[0].rd = '1;
		for (int r = 0; r < num_rows; r++) begin
			for (int i = 0; i < nb; i++) begin
				rows[r].exp_addr[i] = rebase(rows[r].addr[i], rows[r].base[i]);
			end
		end
	endtask

	task automatic clear_beats();
		for (int i = 0; i < nb; i++) begin
			wr_beat[i] = '0;
		end
	endtask

	// data fire alone adds one, response fire alone takes one off
	task automatic note_fires();
		logic any_w;
		logic any_b;
		any_w = 1'b0;
		any_b = 1'b0;
		for (int i = 0; i < nb; i++) begin
			any_w |= wr_beat[i].w_valid & wr_beat[i].w_ready;
			any_b |= wr_beat[i].b_valid & wr_beat[i].b_ready;
		end
		if (any_w && !any_b) begin
			exp_pend++;
		end else if (!any_w && any_b) begin
			exp_pend--;
		end
	endtask

	// one clock edge with outputs sampled on the falling edge after it
	task automatic advance();
		note_fires();
		@(negedge ap_clk);
		check_bit("ap_done", !exp_run && (exp_pend == 0), ap_done);
		check_bit("ap_idle", exp_idle, ap_idle);
		check_bit("core_reset", ap_reset | exp_idle, core_reset);
	endtask

	task automatic run_row(input row_t row);
		int w_left [nb];
		int r_left [nb];
		int edges;
		logic any_w;
		for (int i = 0; i < nb; i++) begin
			w_left[i] = int'(row.wr_cnt[i]);
			r_left[i] = int'(row.rsp_cnt[i]);
			bank_base[i] = row.base[i];
			core_addr[i] = row.addr[i];
		end
		// the core goes back into reset at the start edge
		ap_start = 1'b1;
		exp_run = 1'b1;
		exp_idle = 1'b1;
		advance();
		ap_start = 1'b0;
		for (int i = 0; i < nb; i++) begin
			check_bus_addr($sformatf("bus_addr[%0d]", i), row.exp_addr[i], bus_addr[i]);
		end
		// edges from start until the core leaves reset
		edges = 0;
		while (ap_idle && edges < wait_limit) begin
			@(negedge ap_clk);
			edges++;
			check_bit("ap_done", 1'b0, ap_done);
		end
		if (ap_idle) begin
			$display("timed out waiting for the core to leave reset");
			timeouts++;
			return;
		end
		check_count("start to release edges", `AFU_RESET_DELAY, edges);
		check_bit("core_reset", 1'b0, core_reset);
		exp_idle = 1'b0;
		// busy phase with write traffic
		for (int c = 0; c < row.busy_len; c++) begin
			core_busy = 1'b1;
			clear_beats();
			if (row.mid_reset && c == 2) begin
				ap_reset = 1'b1;
				exp_run = 1'b0;
				exp_idle = 1'b1;
				exp_pend = 0;
				advance();
				ap_reset = 1'b0;
				core_busy = 1'b0;
				advance();
				return;
			end
			any_w = 1'b0;
			for (int i = 0; i < nb; i++) begin
				if (w_left[i] > 0) begin
					wr_beat[i].w_valid = 1'b1;
					wr_beat[i].w_ready = 1'b1;
					w_left[i]--;
					any_w = 1'b1;
				end else begin
					// valid without ready is not a fire
					wr_beat[i].w_valid = 1'($urandom_range(0, 1));
				end
			end
			// responses only for writes already counted
			for (int i = 0; i < nb; i++) begin
				if (c >= 1 && r_left[i] > 0 && (exp_pend > 0 || any_w)) begin
					wr_beat[i].b_valid = 1'b1;
					wr_beat[i].b_ready = 1'b1;
					r_left[i]--;
				end
			end
			advance();
		end
		// core goes quiet and the run ends at the next edge
		core_busy = 1'b0;
		clear_beats();
		exp_run = 1'b0;
		advance();
		repeat (2) advance();
		// missing responses one per cycle until done
		edges = 0;
		while (!ap_done && edges < wait_limit) begin
			clear_beats();
			if (exp_pend > 0) begin
				wr_beat[edges % nb].b_valid = 1'b1;
				wr_beat[edges % nb].b_ready = 1'b1;
			end
			advance();
			edges++;
		end
		clear_beats();
		if (!ap_done) begin
			$display("timed out waiting for ap_done after the core went quiet");
			timeouts++;
		end
	endtask

	initial begin
		void'($urandom(32'hc1dc_de63));
		errors = 0;
		timeouts = 0;
		ap_clk = 1'b0;
		reset = 1'b1;
		ap_reset = 1'b0;
		ap_start = 1'b0;
		core_busy = 1'b0;
		for (int i = 0; i < nb; i++) begin
			bank_base[i] = '0;
			core_addr[i] = '0;
		end
		clear_beats();
		exp_run = 1'b0;
		exp_idle = 1'b1;
		exp_pend = 0;
		build_rows();
		repeat (10) @(negedge ap_clk);
		reset = 1'b0;
		advance();
		for (int r = 0; r < num_rows; r++) begin
			run_row(rows[r]);
			if (timeouts != 0) begin
				break;
			end
		end
		$display("errors: %0d mismatches, %0d timeouts", errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== dv/afu_wrap_props.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "afu_params.svh"

module afu_wrap_props #(
	parameter int cnt_w = $clog2(`AFU_RESET_DELAY + 1)
) (
	input wire                         ap_clk,
	input wire                         reset,
	input wire                         ap_reset,
	input wire afu_pkg::run_status_t   run_status,
	input wire [cnt_w-1:0]             delay_cnt
);
	import afu_pkg::*;

	// busy wait only starts once the core is out of reset
	busy_wait_needs_core: assert property (
		@(posedge ap_clk) disable iff (reset || ap_reset)
		run_status.busy_wait |-> run_status.core_running
	) else $error("busy_wait set while the core is held in reset");

	// core held in reset only inside the delay window
	delay_in_window: assert property (
		@(posedge ap_clk) disable iff (reset || ap_reset)
		!run_status.core_running |-> (delay_cnt < cnt_w'(`AFU_RESET_DELAY))
	) else $error("delay counter past the reset window with the core still in reset");

	// release comes a fixed number of edges after start
	release_after_delay: assert property (
		@(posedge ap_clk) disable iff (reset || ap_reset)
		$rose(run_status.in_run) |-> ##(`AFU_RESET_DELAY) $rose(run_status.core_running)
	) else $error("core_running did not rise at the end of the reset delay");

endmodule

bind afu_run_ctrl afu_wrap_props props0 (
	.ap_clk     (ap_clk),
	.reset      (reset),
	.ap_reset   (ap_reset),
	.run_status (run_status),
	.delay_cnt  (delay_cnt)
);

`default_nettype wire

// ==== logic/afu_wrap.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "afu_params.svh"

module afu_wrap (
	input  wire                             ap_clk,
	input  wire                             reset,
	// host side
	input  wire                             ap_reset,
	input  wire                             ap_start,
	input  wire [`AFU_BUS_ADDR_W-1:0]       bank_base [`AFU_NUM_BANKS],
	// core side
	input  wire                             core_busy,
	input  wire afu_pkg::core_addr_t        core_addr [`AFU_NUM_BANKS],
	input  wire afu_pkg::wr_beat_t          wr_beat [`AFU_NUM_BANKS],
	// bus side
	output wire afu_pkg::bus_addr_t         bus_addr [`AFU_NUM_BANKS],
	// status back to host, reset to core
	output wire                             ap_done,
	output wire                             ap_idle,
	output wire                             core_reset
);
	import afu_pkg::*;

	// run controller state
	run_status_t run_status;

	// no write left unacknowledged
	logic drained;

	// sequences start, core reset release and busy tracking
	afu_run_ctrl run_ctrl0 (
		.ap_clk     (ap_clk),
		.reset      (reset),
		.ap_reset   (ap_reset),
		.ap_start   (ap_start),
		.core_busy  (core_busy),
		.run_status (run_status)
	);

	// memory side: rebasing and write drain
	mem_port_shim shim0 (
		.ap_clk    (ap_clk),
		.reset     (reset),
		.ap_reset  (ap_reset),
		.bank_base (bank_base),
		.core_addr (core_addr),
		.wr_beat   (wr_beat),
		.bus_addr  (bus_addr),
		.drained   (drained)
	);

	// done only once the run is over and all writes have landed
	// no extra register, follows the two conditions in the same cycle
	assign ap_done = ~run_status.in_run & drained;

	// idle while the core is not released
	assign ap_idle = ~run_status.core_running;

	// core sits in reset through system reset, host reset and the start delay
	// stays released after a run until the host pulses ap_reset
	assign core_reset = reset | ap_reset | ~run_status.core_running;

endmodule

`default_nettype wire

// ==== logic/mem_port_shim.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "afu_params.svh"

module mem_port_shim (
	input  wire                             ap_clk,
	input  wire                             reset,
	input  wire                             ap_reset,
	input  wire [`AFU_BUS_ADDR_W-1:0]       bank_base [`AFU_NUM_BANKS],
	input  wire afu_pkg::core_addr_t        core_addr [`AFU_NUM_BANKS],
	input  wire afu_pkg::wr_beat_t          wr_beat [`AFU_NUM_BANKS],
	output wire afu_pkg::bus_addr_t         bus_addr [`AFU_NUM_BANKS],
	output wire                             drained
);
	import afu_pkg::*;

	localparam int bus_w = `AFU_BUS_ADDR_W;

	// a write data beat accepted on any bank this cycle
	logic w_fire;

	// a write response accepted on any bank this cycle
	logic b_fire;

	// writes sent but not yet acknowledged
	logic [`AFU_PEND_W-1:0] pend_cnt;

	// address rebasing, purely combinational
	// core address is zero-extended, carry out of the bus width is dropped
	for (genvar i = 0; i < `AFU_NUM_BANKS; i++) begin : g_bank
		assign bus_addr[i] = '{
			rd: bus_w'(core_addr[i].rd) + bank_base[i],
			wr: bus_w'(core_addr[i].wr) + bank_base[i]
		};
	end

	// fires are OR-ed over banks
	// two banks firing in one cycle still count once, as in the core's usage
	always_comb begin
		wr_beat_t beat;
		w_fire = 1'b0;
		b_fire = 1'b0;
		for (int i = 0; i < `AFU_NUM_BANKS; i++) begin
			beat = wr_beat[i];
			w_fire |= beat.w_valid & beat.w_ready;
			b_fire |= beat.b_valid & beat.b_ready;
		end
	end

	// pending write counter
	// data without response counts up, response without data counts down
	// both or neither leave it where it is
	always_ff @(posedge ap_clk) begin
		if (reset || ap_reset) begin
			pend_cnt <= '0;
		end else if (w_fire && !b_fire) begin
			pend_cnt <= pend_cnt + 1'b1;
		end else if (!w_fire && b_fire) begin
			pend_cnt <= pend_cnt - 1'b1;
		end
	end

	// every write acknowledged
	assign drained = (pend_cnt == '0);

endmodule

`default_nettype wire

// ==== logic/afu_run_ctrl.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "afu_params.svh"

module afu_run_ctrl (
	input  wire                         ap_clk,
	input  wire                         reset,
	input  wire                         ap_reset,
	input  wire                         ap_start,
	input  wire                         core_busy,
	output wire afu_pkg::run_status_t   run_status
);
	import afu_pkg::*;

	// delay counter must hold the value AFU_RESET_DELAY - 1
	localparam int cnt_w = $clog2(`AFU_RESET_DELAY + 1);
	localparam logic [cnt_w-1:0] cnt_last = cnt_w'(`AFU_RESET_DELAY - 1);

	// registered FSM and flags, handed out as one word
	run_status_t status_q;

	// counts edges spent in run, starts from zero at the start edge
	logic [cnt_w-1:0] delay_cnt;

	// host reset and system reset act the same on all state
	logic clear;

	// last edge of the core reset window
	logic delay_done;

	assign clear = reset | ap_reset;
	assign delay_done = (delay_cnt == cnt_last);

	// two-state run machine
	// idle -> run on ap_start, run -> idle once the core has gone busy and quiet
	always_ff @(posedge ap_clk) begin
		if (clear) begin
			status_q <= '0;
		end else if (!status_q.in_run) begin
			// ap_start is only looked at while idle
			if (ap_start) begin
				status_q.in_run <= 1'b1;
				// a new run puts the core back into reset
				status_q.core_running <= 1'b0;
			end
		end else if (!status_q.core_running) begin
			// core still held in reset, wait for the delay to run out
			if (delay_done) begin
				status_q.core_running <= 1'b1;
				status_q.busy_wait <= 1'b1;
			end
		end else if (status_q.busy_wait) begin
			// released core has not yet picked up work
			if (core_busy) begin
				status_q.busy_wait <= 1'b0;
			end
		end else if (!core_busy) begin
			// core went quiet, run is over
			// core_running is left high so the core keeps its state
			status_q.in_run <= 1'b0;
		end
	end

	// reset-delay counter
	// one count per edge in run, zero while idle
	// value past the window is not used, wrap there is harmless
	always_ff @(posedge ap_clk) begin
		if (clear || !status_q.in_run) begin
			delay_cnt <= '0;
		end else begin
			delay_cnt <= delay_cnt + 1'b1;
		end
	end

	assign run_status = status_q;

endmodule

`default_nettype wire

// ==== common/afu_pkg.sv ====
`default_nettype none

`include "afu_params.svh"

package afu_pkg;

	// one bank's core-side read and write address
	typedef struct packed {
		logic [`AFU_CORE_ADDR_W-1:0] rd;
		logic [`AFU_CORE_ADDR_W-1:0] wr;
	} core_addr_t;

	// the same pair after the bank base has been added
	typedef struct packed {
		logic [`AFU_BUS_ADDR_W-1:0] rd;
		logic [`AFU_BUS_ADDR_W-1:0] wr;
	} bus_addr_t;

	// write data and write response handshakes of one bank
	// valid bits come from the core, ready bits from the bus
	typedef struct packed {
		logic w_valid;
		logic w_ready;
		logic b_valid;
		logic b_ready;
	} wr_beat_t;

	// run controller state as seen by the top level
	// in_run is the run/idle FSM bit itself
	typedef struct packed {
		logic in_run;
		logic core_running;
		logic busy_wait;
	} run_status_t;

endpackage

`default_nettype wire

// ==== common/afu_params.svh ====
`ifndef AFU_PARAMS_SVH
`define AFU_PARAMS_SVH

// memory banks served by the address shim
`define AFU_NUM_BANKS 2

// cycles the compute core stays in reset once a run starts
`define AFU_RESET_DELAY 8

// address seen by the core on each bank
`define AFU_CORE_ADDR_W 32

// address on the system bus, also the width of a bank base
`define AFU_BUS_ADDR_W 40

// outstanding write counter, wide enough that it never wraps in practice
`define AFU_PEND_W 16

`endif
